// ==== verification/filter_patterns.hex ====
// per test: one config word (mode in bits 1:0, amount in bits 4:2)
// then four rows of eight 12-bit rgb pixels in raster order
// test 0 passthrough
00000000
123 456 789 abc def 0f0 f0f 5a5
3c3 c3c 1e2 2d1 48b b84 6e9 96e
07f f70 ace eca 135 531 8d2 2d8
fff 000 a50 05a 777 888 e1c c1e
// test 1 median, spikes inside and on the border
00000001
fff 444 444 444 444 444 444 444
444 555 f00 444 555 444 444 444
444 444 444 555 444 0f0 444 333
444 444 444 444 444 444 444 00f
// test 2 blur
00000002
000 f00 0f0 00f fff 000 f0f 0ff
8f0 0f8 f80 123 fed 000 fff 080
fff 000 fff 000 fff 000 fff 000
369 963 c0c 3a3 000 fff 5b5 b5b
// test 3 sharpen, amount 5
00000017
888 888 888 888 888 888 888 888
888 f08 888 080 888 fff 111 888
888 888 0f0 888 000 888 eee 888
888 888 888 888 888 888 888 888

// ==== pix_filter_top.f ====
hw/pix_filter_pkg.sv
hw/window_gen.sv
hw/channel_filter.sv
hw/pixel_merge.sv
hw/filter_regs.sv
hw/pix_filter_top.sv
verification/pix_filter_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module pix_filter_tb \
    -f pix_filter_top.f -o pix_filter_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/pix_filter_sim > sim.log 2>&1 \
    || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

// ==== verification/pix_filter_tb.sv ====
// testbench that feeds the pattern frames to pix_filter_top and checks the output against a model
`timescale 1ns/1ps

module pix_filter_tb;

    localparam int NUM_TESTS = 4;
    localparam int W = pix_filter_pkg::IMG_W;
    localparam int H = pix_filter_pkg::IMG_H;
    localparam int FRAME_PIX = W * H;
    localparam int TEST_WORDS = FRAME_PIX + 1;  // config word followed by the pixels
    localparam int LIMIT = NUM_TESTS * (FRAME_PIX + 3 * W + 20) + 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic        in_sof;
    logic [11:0] in_pix;
    logic        out_valid;
    logic        out_sof;
    logic [11:0] out_pix;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    logic [31:0] pats [NUM_TESTS * TEST_WORDS];
    logic [11:0] exp_pix [NUM_TESTS][FRAME_PIX];
    int          test_errs [NUM_TESTS];
    int          reg_errs;
    int          out_test;
    int          out_idx;
    integer      seed;

    always #5 clk = ~clk;

    pix_filter_top pix_filter_top_inst (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_sof(in_sof), .in_pix(in_pix),
        .out_valid(out_valid), .out_sof(out_sof), .out_pix(out_pix),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    function automatic int floor_div(int num, int den);
        int q;
        q = num / den;
        if (num % den != 0 && num < 0) q = q - 1;  // integer division truncates
        return q;
    endfunction

    // model of one 4-bit channel with smp[4] as the centre
    function automatic int lane_model(int smp[9], pix_filter_pkg::filt_mode_e mode,
                                      int amount, bit border);
        int srt[9];
        int n8;
        int tmp;
        int v;
        n8 = 0;
        for (int i = 0; i < 9; i++) begin
            srt[i] = smp[i];
            if (i != 4) n8 += smp[i];
        end
        if (border || mode == pix_filter_pkg::MODE_PASS) return smp[4];
        if (mode == pix_filter_pkg::MODE_MEDIAN) begin
            for (int i = 0; i < 8; i++) begin
                for (int j = 0; j < 8 - i; j++) begin
                    if (srt[j] > srt[j+1]) begin
                        tmp = srt[j];
                        srt[j] = srt[j+1];
                        srt[j+1] = tmp;
                    end
                end
            end
            return srt[4];
        end
        if (mode == pix_filter_pkg::MODE_BLUR) return (8 * smp[4] + n8) / 16;
        v = smp[4] + floor_div((smp[4] - n8 / 8) * amount, 4);
        return (v < 0) ? 0 : ((v > 15) ? 15 : v);
    endfunction

    task automatic build_expected(int t);
        int base;
        int smp[9];
        int px;
        int py;
        bit border;
        pix_filter_pkg::filt_mode_e mode;
        base = t * TEST_WORDS;
        mode = pix_filter_pkg::filt_mode_e'(pats[base][1:0]);
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                border = x == 0 || x == W - 1 || y == 0 || y == H - 1;
                for (int ch = 0; ch < 3; ch++) begin
                    for (int k = 0; k < 9; k++) begin
                        px = border ? x : x + k % 3 - 1;  // border windows only need c
                        py = border ? y : y + k / 3 - 1;
                        smp[k] = int'((pats[base + 1 + py * W + px] >> (8 - 4 * ch)) & 32'hf);
                    end
                    exp_pix[t][y * W + x][11 - 4 * ch -: 4] =
                        4'(lane_model(smp, mode, int'(pats[base][4:2]), border));
                end
            end
        end
    endtask

    // one wishbone classic cycle that expects the ack one clock after the strobe
    task automatic bus_cycle(input logic we, input logic adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 8);
        rdata = wb_dat_r;
        // first falling edge comes before the strobe is sampled
        assert (wb_ack && waited == 2) else begin
            $display("wb_ack did not come one cycle after the strobe at %0t", $time);
            reg_errs++;
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic write_reg(input logic adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input logic adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    // raster feed with random idle cycles and the idle time the flush needs afterwards
    task automatic send_frame(int t);
        int i;
        i = 0;
        while (i < FRAME_PIX) begin
            @(posedge clk);
            #1;
            if ($random(seed) % 4 == 0) begin
                in_valid = 1'b0;
                in_sof = 1'b0;
            end else begin
                in_valid = 1'b1;
                in_sof = (i == 0);
                in_pix = pats[t * TEST_WORDS + 1 + i][11:0];
                i++;
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_sof = 1'b0;
        repeat (W + 4) @(posedge clk);
    endtask

    always @(negedge clk) begin
        if (rst_n && out_valid && out_test < NUM_TESTS) begin
            assert (out_pix === exp_pix[out_test][out_idx]) else begin
                $display("ERR %0t out_pix test %0d pixel %0d expected %03h got %03h", $time,
                         out_test, out_idx, exp_pix[out_test][out_idx], out_pix);
                test_errs[out_test]++;
            end
            assert (out_sof === (out_idx == 0)) else begin
                $display("ERR %0t out_sof test %0d pixel %0d expected %0b got %0b", $time,
                         out_test, out_idx, out_idx == 0, out_sof);
                test_errs[out_test]++;
            end
            if (out_idx == FRAME_PIX - 1) begin
                $display("test %0d cfg %02h: %0d errors", out_test,
                         pats[out_test * TEST_WORDS][7:0], test_errs[out_test]);
                out_idx <= 0;
                out_test <= out_test + 1;
            end else begin
                out_idx <= out_idx + 1;
            end
        end else begin
            assert (!(rst_n && out_valid)) else begin
                $display("output pixel after the last frame at %0t", $time);
                reg_errs++;
            end
        end
    end

    initial begin
        logic [31:0] rd;
        int failed;
        int total;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_sof = 1'b0;
        in_pix = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 1'b0;
        wb_dat_w = '0;
        seed = 32'hf731_4cbe;
        reg_errs = 0;
        out_test = 0;
        out_idx = 0;
        for (int t = 0; t < NUM_TESTS; t++) test_errs[t] = 0;
        $readmemh("verification/filter_patterns.hex", pats);
        for (int t = 0; t < NUM_TESTS; t++) build_expected(t);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        write_reg(pix_filter_pkg::REG_CTRL, pats[0]);
        for (int t = 0; t < NUM_TESTS; t++) begin
            fork
                send_frame(t);
                begin
                    // next frame's mode lands halfway through this one
                    if (t + 1 < NUM_TESTS) begin
                        repeat (FRAME_PIX / 2) @(posedge clk);
                        write_reg(pix_filter_pkg::REG_CTRL, pats[(t + 1) * TEST_WORDS]);
                    end
                end
            join
        end
        wait (out_test == NUM_TESTS);
        repeat (4) @(posedge clk);
        read_reg(pix_filter_pkg::REG_CTRL, rd);
        assert (rd === (pats[(NUM_TESTS - 1) * TEST_WORDS] & 32'h1f)) else begin
            $display("ERR %0t wb_dat_r REG_CTRL expected %08h got %08h", $time,
                     pats[(NUM_TESTS - 1) * TEST_WORDS] & 32'h1f, rd);
            reg_errs++;
        end
        read_reg(pix_filter_pkg::REG_FRAMES, rd);
        assert (rd === 32'(NUM_TESTS)) else begin
            $display("ERR %0t wb_dat_r REG_FRAMES expected %08h got %08h", $time, NUM_TESTS, rd);
            reg_errs++;
        end
        write_reg(pix_filter_pkg::REG_FRAMES, 32'h0000_00aa);  // frame count is read only
        read_reg(pix_filter_pkg::REG_FRAMES, rd);
        assert (rd === 32'(NUM_TESTS)) else begin
            $display("ERR %0t wb_dat_r REG_FRAMES expected %08h got %08h", $time, NUM_TESTS, rd);
            reg_errs++;
        end
        $display("test %0d registers: %0d errors", NUM_TESTS, reg_errs);
        failed = (reg_errs != 0);
        total = reg_errs;
        for (int t = 0; t < NUM_TESTS; t++) begin
            failed += (test_errs[t] != 0);
            total += test_errs[t];
        end
        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS + 1, failed, total);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout after %0d cycles, output frames incomplete", LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== hw/pix_filter_top.sv ====
// top level of the 3x3 pixel filter: feeder, three colour lanes, drain and wishbone registers
`timescale 1ns/1ps

module pix_filter_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  logic                             in_sof,
    input  logic [pix_filter_pkg::PIX_W-1:0] in_pix,
    output logic                             out_valid,
    output logic                             out_sof,
    output logic [pix_filter_pkg::PIX_W-1:0] out_pix,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic                             wb_adr,
    input  logic [31:0]                      wb_dat_w,
    output logic [31:0]                      wb_dat_r,
    output logic                             wb_ack
);

    pix_filter_pkg::filt_cfg_t cfg;
    pix_filter_pkg::win_t      win;
    pix_filter_pkg::lane_res_t lane_res [pix_filter_pkg::NUM_CH];
    logic                      frame_pulse;

    window_gen window_gen_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_sof   (in_sof),
        .in_pix   (in_pix),
        .cfg      (cfg),
        .win      (win)
    );

    // lane k works on bits [11-4k : 8-4k]
    for (genvar k = 0; k < pix_filter_pkg::NUM_CH; k++) begin : g_lane
        channel_filter #(.LANE(k)) channel_filter_inst (
            .clk   (clk),
            .rst_n (rst_n),
            .win   (win),
            .res   (lane_res[k])
        );
    end

    pixel_merge pixel_merge_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .res         (lane_res),
        .out_valid   (out_valid),
        .out_sof     (out_sof),
        .out_pix     (out_pix),
        .frame_pulse (frame_pulse)
    );

    filter_regs filter_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .frame_pulse (frame_pulse),
        .cfg         (cfg)
    );

endmodule

// ==== hw/filter_regs.sv ====
// wishbone classic slave with the filter control register and the completed-frame count
`timescale 1ns/1ps

module filter_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic                      wb_adr,
    input  logic [31:0]               wb_dat_w,
    output logic [31:0]               wb_dat_r,
    output logic                      wb_ack,
    input  logic                      frame_pulse,
    output pix_filter_pkg::filt_cfg_t cfg
);

    logic                                   req;
    logic [pix_filter_pkg::FRAME_CNT_W-1:0] frames;

    assign req = wb_cyc && wb_stb && !wb_ack;  // one ack per strobe

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            cfg <= '{mode: pix_filter_pkg::MODE_PASS, amount: '0};
            frames <= '0;
        end else begin
            wb_ack <= req;
            if (req && wb_we && wb_adr == pix_filter_pkg::REG_CTRL) begin
                cfg.mode <= pix_filter_pkg::filt_mode_e'(wb_dat_w[1:0]);
                cfg.amount <= wb_dat_w[4:2];
            end
            if (frame_pulse) frames <= frames + 1'b1;  // frame count is read only
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (wb_adr == pix_filter_pkg::REG_CTRL) begin
                wb_dat_r <= {27'd0, cfg.amount, cfg.mode};
            end else begin
                wb_dat_r <= {{(32 - pix_filter_pkg::FRAME_CNT_W){1'b0}}, frames};
            end
        end
    end

    // master must hold the strobe until it sees the ack
    a_ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_stb && wb_cyc)
        else $error("filter_regs: wb_ack without wb_stb");

endmodule

// ==== hw/pixel_merge.sv ====
// drain that joins the three lane results into one pixel and flags the last pixel of each frame
`timescale 1ns/1ps

module pixel_merge (
    input  logic                             clk,
    input  logic                             rst_n,
    input  pix_filter_pkg::lane_res_t        res [pix_filter_pkg::NUM_CH],
    output logic                             out_valid,
    output logic                             out_sof,
    output logic [pix_filter_pkg::PIX_W-1:0] out_pix,
    output logic                             frame_pulse
);

    logic [pix_filter_pkg::FCW-1:0] cnt;  // pixels sent so far in this frame
    logic [pix_filter_pkg::FCW-1:0] idx;

    assign idx = res[0].sof ? '0 : cnt;

    always_ff @(posedge clk) begin
        for (int k = 0; k < pix_filter_pkg::NUM_CH; k++) begin
            out_pix[pix_filter_pkg::PIX_W-1-pix_filter_pkg::CH_W*k -: pix_filter_pkg::CH_W]
                <= res[k].val;
        end
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_sof <= 1'b0;
            frame_pulse <= 1'b0;
            cnt <= '0;
        end else begin
            out_valid <= res[0].valid;
            out_sof <= res[0].valid && res[0].sof;
            frame_pulse <= res[0].valid
                           && idx == pix_filter_pkg::FCW'(pix_filter_pkg::FRAME_PIX - 1);
            if (res[0].valid) cnt <= idx + 1'b1;
        end
    end

    for (genvar k = 1; k < pix_filter_pkg::NUM_CH; k++) begin : g_agree
        a_lanes_agree: assert property (@(posedge clk) disable iff (!rst_n)
            res[k].valid == res[0].valid && res[k].sof == res[0].sof)
            else $error("pixel_merge: lane %0d out of step", k);
    end

endmodule

// ==== hw/channel_filter.sv ====
// one colour lane filtering its channel of each 3x3 window, instantiated three times by the top level
`timescale 1ns/1ps

module channel_filter #(
    parameter int LANE = 0  // 0 red, 1 green, 2 blue
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pix_filter_pkg::win_t      win,
    output pix_filter_pkg::lane_res_t res
);

    typedef logic [pix_filter_pkg::CH_W-1:0] smp_t;

    function automatic smp_t min2(smp_t a, smp_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic smp_t max2(smp_t a, smp_t b);
        return (a > b) ? a : b;
    endfunction

    function automatic smp_t med3(smp_t a, smp_t b, smp_t c);
        return max2(min2(a, b), min2(max2(a, b), c));
    endfunction

    smp_t                      s [9];
    logic [6:0]                n8;       // sum of the eight neighbours
    smp_t                      lo_q [3];  // per-row sorted triples
    smp_t                      mid_q [3];
    smp_t                      hi_q [3];
    logic [6:0]                n8_q;
    smp_t                      c_q;
    logic                      v1_q;
    logic                      sof1_q;
    logic                      edge1_q;
    pix_filter_pkg::filt_cfg_t cfg1_q;
    smp_t                      med;
    logic [7:0]                blur_sum;
    logic signed [5:0]         diff;
    logic signed [8:0]         sharp;
    smp_t                      sharp_c;
    smp_t                      sel;

    always_comb begin
        n8 = '0;
        for (int i = 0; i < 9; i++) begin
            s[i] = win.pix[i][pix_filter_pkg::PIX_W-1-pix_filter_pkg::CH_W*LANE -:
                              pix_filter_pkg::CH_W];
            if (i != 4) n8 = n8 + 7'(s[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < 3; r++) begin
            lo_q[r] <= min2(min2(s[3*r], s[3*r+1]), s[3*r+2]);
            mid_q[r] <= med3(s[3*r], s[3*r+1], s[3*r+2]);
            hi_q[r] <= max2(max2(s[3*r], s[3*r+1]), s[3*r+2]);
        end
        n8_q <= n8;
        c_q <= s[4];
        sof1_q <= win.sof;
        edge1_q <= win.at_edge;
        cfg1_q <= win.cfg;
        if (!rst_n) v1_q <= 1'b0;
        else v1_q <= win.valid;
    end

    always_comb begin
        // median of nine from the row triples
        med = med3(max2(max2(lo_q[0], lo_q[1]), lo_q[2]),
                   med3(mid_q[0], mid_q[1], mid_q[2]),
                   min2(min2(hi_q[0], hi_q[1]), hi_q[2]));
        blur_sum = {1'b0, c_q, 3'b000} + {1'b0, n8_q};  // 8c + n8 reaches at most 240
        diff = $signed({2'b00, c_q}) - $signed({2'b00, n8_q[6:3]});
        sharp = $signed({5'b00000, c_q}) + ((diff * $signed({1'b0, cfg1_q.amount})) >>> 2);
        if (sharp < 0) sharp_c = '0;
        else if (sharp > 9'sd15) sharp_c = '1;
        else sharp_c = sharp[3:0];
        if (edge1_q) begin
            sel = c_q;  // border pixels pass through
        end else begin
            case (cfg1_q.mode)
                pix_filter_pkg::MODE_MEDIAN:  sel = med;
                pix_filter_pkg::MODE_BLUR:    sel = blur_sum[7:4];
                pix_filter_pkg::MODE_SHARPEN: sel = sharp_c;
                default:                      sel = c_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        res.val <= sel;
        if (!rst_n) begin
            res.valid <= 1'b0;
            res.sof <= 1'b0;
        end else begin
            res.valid <= v1_q;
            res.sof <= sof1_q;
        end
    end

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !res.valid && !win.valid)
        else $error("channel_filter: valid during reset");

endmodule

// ==== hw/window_gen.sv ====
// feeder that turns the raster pixel stream into 3x3 windows, one per pixel plus an end-of-frame flush
`timescale 1ns/1ps

module window_gen (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  logic                             in_sof,
    input  logic [pix_filter_pkg::PIX_W-1:0] in_pix,
    input  pix_filter_pkg::filt_cfg_t        cfg,
    output pix_filter_pkg::win_t             win
);

    logic [pix_filter_pkg::PIX_W-1:0]           lb0 [pix_filter_pkg::IMG_W];  // row y-2
    logic [pix_filter_pkg::PIX_W-1:0]           lb1 [pix_filter_pkg::IMG_W];  // row y-1
    logic [2:0][2:0][pix_filter_pkg::PIX_W-1:0] sr;   // [row][col], col 0 on the left
    logic [2:0][pix_filter_pkg::PIX_W-1:0]      col;  // column shifted in at the right
    logic [pix_filter_pkg::XW-1:0]              in_x;
    logic [pix_filter_pkg::YW-1:0]              in_y;
    logic [pix_filter_pkg::XW-1:0]              out_x;  // centre of the next window
    logic [pix_filter_pkg::YW-1:0]              out_y;
    logic [pix_filter_pkg::FW-1:0]              fcnt;
    logic [pix_filter_pkg::XW-1:0]              rd_idx;
    logic                                       flushing;
    logic                                       in_last;
    logic                                       in_emit;
    logic                                       emit;
    pix_filter_pkg::filt_cfg_t                  cfg_q;      // config of the current frame
    pix_filter_pkg::filt_cfg_t                  win_cfg_q;
    logic                                       win_valid_q;
    logic                                       win_sof_q;
    logic                                       win_edge_q;

    assign in_last = in_valid && in_x == pix_filter_pkg::XW'(pix_filter_pkg::IMG_W - 1)
                     && in_y == pix_filter_pkg::YW'(pix_filter_pkg::IMG_H - 1);
    // windows trail the input by one line plus one pixel
    assign in_emit = in_valid && (in_y > pix_filter_pkg::YW'(1) || (in_y == 1 && in_x != 0));
    assign emit = in_emit || flushing;

    // flush reads a phantom row below the frame; index IMG_W only feeds the unused right column
    assign rd_idx = in_valid ? in_x :
                    (fcnt < pix_filter_pkg::FW'(pix_filter_pkg::IMG_W)) ?
                    fcnt[pix_filter_pkg::XW-1:0] : '0;

    always_comb begin
        col[0] = lb0[rd_idx];
        col[1] = lb1[rd_idx];
        col[2] = in_valid ? in_pix : '0;
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            lb0[in_x] <= lb1[in_x];
            lb1[in_x] <= in_pix;
        end
        if (in_valid || flushing) begin
            for (int r = 0; r < 3; r++) begin
                sr[r][0] <= sr[r][1];
                sr[r][1] <= sr[r][2];
                sr[r][2] <= col[r];
            end
        end
        if (emit) begin
            win_sof_q <= out_x == 0 && out_y == 0;
            win_edge_q <= out_x == 0 || out_x == pix_filter_pkg::XW'(pix_filter_pkg::IMG_W - 1)
                          || out_y == 0 || out_y == pix_filter_pkg::YW'(pix_filter_pkg::IMG_H - 1);
            win_cfg_q <= cfg_q;  // latched before a concurrent sof can change it
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_x <= '0;
            in_y <= '0;
            out_x <= '0;
            out_y <= '0;
            fcnt <= '0;
            flushing <= 1'b0;
            win_valid_q <= 1'b0;
            cfg_q <= '{mode: pix_filter_pkg::MODE_PASS, amount: '0};
        end else begin
            win_valid_q <= emit;
            if (in_valid && in_sof) cfg_q <= cfg;
            if (in_valid) begin
                if (in_x == pix_filter_pkg::XW'(pix_filter_pkg::IMG_W - 1)) begin
                    in_x <= '0;
                    in_y <= (in_y == pix_filter_pkg::YW'(pix_filter_pkg::IMG_H - 1)) ?
                            '0 : in_y + 1'b1;
                end else begin
                    in_x <= in_x + 1'b1;
                end
            end
            if (in_last) begin
                flushing <= 1'b1;
                fcnt <= '0;
            end else if (flushing) begin
                fcnt <= fcnt + 1'b1;
                if (fcnt == pix_filter_pkg::FW'(pix_filter_pkg::IMG_W)) flushing <= 1'b0;
            end
            if (emit) begin
                if (out_x == pix_filter_pkg::XW'(pix_filter_pkg::IMG_W - 1)) begin
                    out_x <= '0;
                    out_y <= (out_y == pix_filter_pkg::YW'(pix_filter_pkg::IMG_H - 1)) ?
                             '0 : out_y + 1'b1;
                end else begin
                    out_x <= out_x + 1'b1;
                end
            end
        end
    end

    always_comb begin
        win.valid = win_valid_q;
        win.sof = win_sof_q;
        win.at_edge = win_edge_q;
        win.cfg = win_cfg_q;
        win.pix = sr;  // [r][c] packs to index 3r+c
    end

    // last flush step only reads the register chain, so the next frame may start there
    a_no_input_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid || in_sof |-> !flushing || fcnt == pix_filter_pkg::FW'(pix_filter_pkg::IMG_W))
        else $error("window_gen: source not idle during flush");
    a_sof_at_line_start: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_sof |-> in_x == '0)
        else $error("window_gen: in_sof away from x = 0");

endmodule

// ==== hw/pix_filter_pkg.sv ====
// shared geometry, types and register map for the 3x3 pixel filter, referenced by scoped names
package pix_filter_pkg;

    // frame geometry, kept small for simulation
    localparam int IMG_W = 8;
    localparam int IMG_H = 4;
    localparam int FRAME_PIX = IMG_W * IMG_H;

    localparam int CH_W = 4;    // bits per colour channel
    localparam int NUM_CH = 3;
    localparam int PIX_W = 12;  // rgb 4:4:4

    localparam int XW = $clog2(IMG_W);
    localparam int YW = $clog2(IMG_H);
    localparam int FW = $clog2(IMG_W + 1);      // flush counter runs 0..IMG_W
    localparam int FCW = $clog2(FRAME_PIX + 1);
    localparam int FRAME_CNT_W = 16;

    // wishbone word addresses
    localparam logic REG_CTRL = 1'b0;
    localparam logic REG_FRAMES = 1'b1;

    typedef enum logic [1:0] {
        MODE_PASS    = 2'd0,
        MODE_MEDIAN  = 2'd1,
        MODE_BLUR    = 2'd2,
        MODE_SHARPEN = 2'd3
    } filt_mode_e;

    typedef struct packed {
        filt_mode_e mode;
        logic [2:0] amount;  // sharpening gain 0..7
    } filt_cfg_t;

    // window from the feeder, pix[0] is top left, pix[4] the centre
    typedef struct packed {
        logic                       valid;
        logic                       sof;
        logic                       at_edge;  // centre on the frame border
        filt_cfg_t                  cfg;
        logic [8:0][PIX_W-1:0]      pix;
    } win_t;

    typedef struct packed {
        logic            valid;
        logic            sof;
        logic [CH_W-1:0] val;
    } lane_res_t;

endpackage
